//--- bankMemory.sv
/*
 * One bank of word memory behind a Wishbone classic slave port.
 * Reads and writes happen on the first strobe cycle; ack follows one
 * cycle later and lasts a single cycle.
 */

`timescale 1ns/1ps
`default_nettype none

`include "execUnit_defines.svh"

module bankMemory
	import execUnitPkg::*;
(
	input	wire logic		clock,
	input	wire logic		reset,
	input	wire logic		cyc,
	input	wire logic		stb,
	input	wire logic		we,
	input	wire bankAddr_t	adr,
	input	wire data_t		datWrite,
	output	data_t			datRead,
	output	logic			ack
);

	data_t	mem [2**`BANK_ADDR_WIDTH];
	logic	access;

	// New request only while no acknowledge is outstanding
	assign access = cyc && stb && !ack;

	always_ff @(posedge clock) begin
		if (reset) begin
			ack <= 1'b0;
		end else begin
			ack <= access;
		end
	end

	always_ff @(posedge clock) begin
		if (access && we) begin
			mem[adr] <= datWrite;
		end
		if (access) begin
			datRead <= mem[adr];
		end
	end

endmodule

`default_nettype wire

//--- execCore.f
+incdir+.
execUnitPkg.sv
scalarAlu.sv
loadStoreUnit.sv
execUnit.sv
bankMemory.sv
execCore.sv
execCoreChecker.sv
execCoreTb.sv

//--- execCore.sv
/*
 * RTL top: the execution stage with its even and odd bank memories.
 * Only the command, ready and write-back ports face the outside.
 */

`timescale 1ns/1ps
`default_nettype none

module execCore
	import execUnitPkg::*;
(
	input	wire logic			clock,
	input	wire logic			reset,
	input	wire execCommand_t	command,
	output	logic				ready,
	output	writeBack_t			aluResult,
	output	writeBack_t			moveResult,
	output	writeBack_t			evenLdStResult,
	output	writeBack_t			oddLdStResult,
	output	logic				evenStoreDone,
	output	logic				oddStoreDone
);

	// Bank buses
	logic		evenCyc, evenStb, evenWe, evenAck;
	logic		oddCyc, oddStb, oddWe, oddAck;
	bankAddr_t	evenAdr, oddAdr;
	data_t		evenDatWrite, evenDatRead;
	data_t		oddDatWrite, oddDatRead;

	execUnit execUnit_i (
		.clock(clock), .reset(reset), .command(command), .ready(ready),
		.aluResult(aluResult), .moveResult(moveResult),
		.evenLdStResult(evenLdStResult), .oddLdStResult(oddLdStResult),
		.evenStoreDone(evenStoreDone), .oddStoreDone(oddStoreDone),
		.evenCyc(evenCyc), .evenStb(evenStb), .evenWe(evenWe), .evenAdr(evenAdr),
		.evenDatWrite(evenDatWrite), .evenDatRead(evenDatRead), .evenAck(evenAck),
		.oddCyc(oddCyc), .oddStb(oddStb), .oddWe(oddWe), .oddAdr(oddAdr),
		.oddDatWrite(oddDatWrite), .oddDatRead(oddDatRead), .oddAck(oddAck)
	);

	bankMemory evenBank (
		.clock(clock), .reset(reset), .cyc(evenCyc), .stb(evenStb), .we(evenWe),
		.adr(evenAdr), .datWrite(evenDatWrite), .datRead(evenDatRead), .ack(evenAck)
	);

	bankMemory oddBank (
		.clock(clock), .reset(reset), .cyc(oddCyc), .stb(oddStb), .we(oddWe),
		.adr(oddAdr), .datWrite(oddDatWrite), .datRead(oddDatRead), .ack(oddAck)
	);

endmodule

`default_nettype wire

//--- execCoreChecker.sv
/*
 * Watcher for the execution core testbench. Predicts every accepted
 * command with its own reference rules and a word-addressed memory model,
 * then matches each write-back by tag as it comes out.
 */

`timescale 1ns/1ps
`default_nettype none

`include "execUnit_defines.svh"

module execCoreChecker
	import execUnitPkg::*;
(
	input	wire logic			clock,
	input	wire logic			reset,
	input	wire execCommand_t	command,
	input	wire logic			ready,
	input	wire writeBack_t	aluResult,
	input	wire writeBack_t	moveResult,
	input	wire writeBack_t	evenLdStResult,
	input	wire writeBack_t	oddLdStResult,
	input	wire logic			evenStoreDone,
	input	wire logic			oddStoreDone,
	output	int					errorCount,
	output	int					pendingCount
);

	localparam int tagCount = 2**`TAG_WIDTH;

	logic		pending [tagCount];		// Tag has a result still to come
	int			expChannel [tagCount];	// 0 alu, 1 move, 2 even, 3 odd
	regIndex_t	expDst [tagCount];
	data_t		expData [tagCount];
	int			issueCycle [tagCount];
	data_t		modelMem [2**(`BANK_ADDR_WIDTH+1)];
	int			storesOutstanding [2];	// Stores in flight per bank
	int			cycle;
	logic		seenCommand;

	function automatic string channelName(input int channel);
		case (channel)
			0:			return "aluResult";
			1:			return "moveResult";
			2:			return "evenLdStResult";
			default:	return "oddLdStResult";
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Expected value of one command
	//////////////////////////////////////////////////
	function automatic data_t predictData(input execCommand_t c);
		wordAddr_t addr;
		addr = wordAddr_t'(c.src1 + c.src2);
		if (c.opType == opMove) begin
			return (c.aluOp == aluAdd) ? c.src1 : c.src3;	// Otherwise immediate
		end
		if (c.opType == opLoad) begin
			return modelMem[addr];
		end
		case (c.aluOp)
			aluAdd:			return c.src1 + c.src2;
			aluSub:			return c.src1 - c.src2;
			aluAnd:			return c.src1 & c.src2;
			aluOr:			return c.src1 | c.src2;
			aluXor:			return c.src1 ^ c.src2;
			aluShiftLeft:	return c.src1 << c.src2[4:0];
			aluShiftRight:	return c.src1 >> c.src2[4:0];		// Zero fill
			default:		return ($signed(c.src1) < $signed(c.src2)) ? 1 : 0;
		endcase
	endfunction

	task automatic acceptCommand(input execCommand_t c);
		wordAddr_t addr;
		int channel;
		addr = wordAddr_t'(c.src1 + c.src2);
		if (c.opType == opArith) begin
			channel = 0;
		end else if (c.opType == opMove) begin
			channel = 1;
		end else begin
			channel = addr[0] ? 3 : 2;
		end
		if (c.opType == opStore) begin
			modelMem[addr] = c.src3;
			storesOutstanding[addr[0]]++;
			pendingCount++;
		end else if (pending[c.tag]) begin
			$display("tag %0d was issued again while still outstanding", c.tag);
			errorCount++;
		end else begin
			pending[c.tag]		= 1'b1;
			expChannel[c.tag]	= channel;
			expDst[c.tag]		= c.dst;
			expData[c.tag]		= predictData(c);
			issueCycle[c.tag]	= cycle;
			pendingCount++;
		end
	endtask

	task automatic checkResult(input int channel, input writeBack_t r);
		string name;
		name = channelName(channel);
		if (!pending[r.tag]) begin
			$display("%s returned tag %0d with no command outstanding", name, r.tag);
			errorCount++;
		end else begin
			if (expChannel[r.tag] != channel) begin
				$display("tag %0d came back on %s instead of %s", r.tag, name,
					channelName(expChannel[r.tag]));
				errorCount++;
			end
			if (r.dst !== expDst[r.tag]) begin
				$display("ERROR %s.dst tag %h: got %h, expected %h", name, r.tag, r.dst,
					expDst[r.tag]);
				errorCount++;
			end
			if (r.data !== expData[r.tag]) begin
				$display("ERROR %s.data tag %h: got %h, expected %h", name, r.tag, r.data,
					expData[r.tag]);
				errorCount++;
			end
			// ALU takes two cycles, move one
			if (channel < 2 && cycle - issueCycle[r.tag] != 2 - channel) begin
				$display("%s for tag %0d arrived %0d cycles after issue instead of %0d",
					name, r.tag, cycle - issueCycle[r.tag], 2 - channel);
				errorCount++;
			end
			pending[r.tag] = 1'b0;
			pendingCount--;
		end
	endtask

	task automatic storeFinished(input int bank);
		if (storesOutstanding[bank] == 0) begin
			$display("store-done pulse on the %s bank with no store outstanding",
				bank ? "odd" : "even");
			errorCount++;
		end else begin
			storesOutstanding[bank]--;
			pendingCount--;
		end
	endtask

	//////////////////////////////////////////////////
	// Per-edge sampling
	//////////////////////////////////////////////////
	always @(posedge clock) begin
		if (reset) begin
			for (int t = 0; t < tagCount; t++) begin
				pending[t] = 1'b0;
			end
			storesOutstanding[0]	= 0;
			storesOutstanding[1]	= 0;
			errorCount				= 0;
			pendingCount			= 0;
			cycle					= 0;
			seenCommand				= 1'b0;
		end else begin
			cycle++;
			if (command.valid === 1'b1) begin
				seenCommand = 1'b1;
			end
			if (!seenCommand) begin		// Quiet outputs until the first command
				if (ready !== 1'b1 || aluResult.valid !== 1'b0 || moveResult.valid !== 1'b0
						|| evenLdStResult.valid !== 1'b0 || oddLdStResult.valid !== 1'b0
						|| evenStoreDone !== 1'b0 || oddStoreDone !== 1'b0) begin
					$display("after reset ready is not high or an output is active at cycle %0d",
						cycle);
					errorCount++;
				end
			end
			// Arith and move never wait on a bank
			if (command.valid === 1'b1 && ready !== 1'b1
					&& (command.opType == opArith || command.opType == opMove)) begin
				$display("ready is low for an arith or move command at cycle %0d", cycle);
				errorCount++;
			end
			// Completions first so a tag can be reused on the same edge
			if (aluResult.valid === 1'b1) checkResult(0, aluResult);
			if (moveResult.valid === 1'b1) checkResult(1, moveResult);
			if (evenLdStResult.valid === 1'b1) checkResult(2, evenLdStResult);
			if (oddLdStResult.valid === 1'b1) checkResult(3, oddLdStResult);
			if (evenStoreDone === 1'b1) storeFinished(0);
			if (oddStoreDone === 1'b1) storeFinished(1);
			if (command.valid === 1'b1 && ready === 1'b1) begin
				acceptCommand(command);
			end
		end
	end

endmodule

`default_nettype wire

//--- execCoreTb.sv
/*
 * Testbench top for the execution core. Generates clock and reset, issues
 * directed and random commands, and reports one line per test. All result
 * comparison happens in the checker instance.
 */

`timescale 1ns/1ps
`default_nettype none

module execCoreTb
	import execUnitPkg::*;
();

	localparam int resetCycles		= 16;
	localparam int arithCount		= 24;
	localparam int moveCount		= 8;
	localparam int pairCount		= 4;		// Store plus load each
	localparam int pressureCount	= 8;
	localparam int mixedCount		= 32;
	localparam int commandCount		= arithCount + moveCount + 2 * pairCount
									+ pressureCount + mixedCount;
	localparam int timeoutCycles	= 20 * commandCount + resetCycles;
	localparam logic [31:0] seed	= 32'd58648;

	logic			clock;
	logic			reset;
	execCommand_t	command;
	logic			ready;
	writeBack_t		aluResult;
	writeBack_t		moveResult;
	writeBack_t		evenLdStResult;
	writeBack_t		oddLdStResult;
	logic			evenStoreDone;
	logic			oddStoreDone;
	int				checkErrors;
	int				pendingCount;

	logic [31:0]	rngState;
	issueTag_t		nextTag;
	wordAddr_t		storedAddrs [$];	// Loads only go here
	int				stallCycles;
	int				tbErrors;
	int				reportedErrors;
	int				testsRun;
	int				testsFailed;
	int				cycleCount;

	execCore dut_i (
		.clock(clock), .reset(reset), .command(command), .ready(ready),
		.aluResult(aluResult), .moveResult(moveResult),
		.evenLdStResult(evenLdStResult), .oddLdStResult(oddLdStResult),
		.evenStoreDone(evenStoreDone), .oddStoreDone(oddStoreDone)
	);

	execCoreChecker checker_i (
		.clock(clock), .reset(reset), .command(command), .ready(ready),
		.aluResult(aluResult), .moveResult(moveResult),
		.evenLdStResult(evenLdStResult), .oddLdStResult(oddLdStResult),
		.evenStoreDone(evenStoreDone), .oddStoreDone(oddStoreDone),
		.errorCount(checkErrors), .pendingCount(pendingCount)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;		// 100 ns period
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < timeoutCycles) begin
			@(posedge clock);
			cycleCount++;
		end
		$display("timeout after %0d cycles with %0d results outstanding", cycleCount,
			pendingCount);
		$display("tests failed");
		$finish;
	end

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////
	function automatic logic [31:0] nextRandom();
		logic [31:0] x;
		x = rngState;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		rngState = x;
		return x;
	endfunction

	function automatic execCommand_t makeCommand(input opType_t op, input aluOp_t fn,
			input data_t a, input data_t b, input data_t c);
		execCommand_t cmd;
		cmd.valid	= 1'b1;
		cmd.opType	= op;
		cmd.aluOp	= fn;
		cmd.dst		= regIndex_t'(nextRandom());
		cmd.tag		= '0;		// Filled in at issue
		cmd.src1	= a;
		cmd.src2	= b;
		cmd.src3	= c;
		return cmd;
	endfunction

	// Random base plus offset so that the sum lands on addr
	function automatic execCommand_t makeMemCommand(input logic store, input wordAddr_t addr,
			input data_t value);
		data_t base;
		base = nextRandom();
		return makeCommand(store ? opStore : opLoad, aluAdd, base, data_t'(addr) - base, value);
	endfunction

	task automatic issueCommand(input execCommand_t cmd);
		cmd.tag = nextTag;
		nextTag = nextTag + 1'b1;
		command = cmd;
		@(negedge clock);
		while (!ready) begin		// Held until the bank frees up
			stallCycles++;
			@(negedge clock);
		end
		@(posedge clock);
		#1;
		command.valid = 1'b0;
	endtask

	task automatic waitForDrain();
		do begin
			@(posedge clock);
			#1;
		end while (pendingCount != 0);
	endtask

	task automatic reportTest(input string name);
		int errors;
		errors = checkErrors + tbErrors - reportedErrors;
		reportedErrors = checkErrors + tbErrors;
		testsRun++;
		if (errors != 0) begin
			testsFailed++;
		end
		$display("test %0d %-14s %s (%0d errors)", testsRun, name,
			(errors == 0) ? "ok" : "FAILED", errors);
	endtask

	//////////////////////////////////////////////////
	// Test sequence
	//////////////////////////////////////////////////
	initial begin
		int i;
		data_t a;
		data_t b;
		wordAddr_t addr;
		aluOp_t fn;
		execCommand_t cmd;
		rngState		= seed;
		nextTag			= '0;
		stallCycles		= 0;
		tbErrors		= 0;
		reportedErrors	= 0;
		testsRun		= 0;
		testsFailed		= 0;
		command			= '0;
		reset			= 1'b1;
		repeat (resetCycles) @(posedge clock);
		#1;
		reset = 1'b0;

		repeat (6) @(posedge clock);		// Idle outputs watched by the checker
		#1;
		reportTest("resetIdle");

		for (i = 0; i < arithCount; i++) begin
			a = nextRandom();
			b = nextRandom();
			if (i >= 8 && i < 16) a[31] = 1'b1;		// Negative first operand
			if (i >= 16) b[31] = 1'b1;
			issueCommand(makeCommand(opArith, aluOp_t'(i[2:0]), a, b, nextRandom()));
		end
		waitForDrain();
		reportTest("arith");

		for (i = 0; i < moveCount; i++) begin
			fn = i[0] ? aluOp_t'(i[2:0]) : aluAdd;	// Odd ones take the immediate
			issueCommand(makeCommand(opMove, fn, nextRandom(), nextRandom(), nextRandom()));
		end
		waitForDrain();
		reportTest("move");

		for (i = 0; i < pairCount; i++) begin
			addr = wordAddr_t'(nextRandom());
			addr[0] = i[0];		// Alternate banks
			storedAddrs.push_back(addr);
			issueCommand(makeMemCommand(1'b1, addr, nextRandom()));
			issueCommand(makeMemCommand(1'b0, addr, '0));
		end
		waitForDrain();
		reportTest("storeLoad");

		stallCycles = 0;
		for (i = 0; i < pressureCount; i++) begin
			addr = storedAddrs[i / 4 + 2 * (i % 2)];	// First half even, then odd
			issueCommand(makeMemCommand(!i[0], addr, nextRandom()));
		end
		waitForDrain();
		if (stallCycles == 0) begin
			$display("ready never went low for a command to a busy bank");
			tbErrors++;
		end
		reportTest("backPressure");

		for (i = 0; i < mixedCount; i++) begin
			a = nextRandom();
			case (a[1:0])
				2'd0: cmd = makeCommand(opArith, aluOp_t'(a[4:2]), nextRandom(), nextRandom(), '0);
				2'd1: cmd = makeCommand(opMove, aluOp_t'(a[4:2]), nextRandom(), nextRandom(),
					nextRandom());
				2'd2: cmd = makeMemCommand(1'b0, storedAddrs[a[15:8] % storedAddrs.size()], '0);
				default: begin
					addr = wordAddr_t'(nextRandom());
					storedAddrs.push_back(addr);
					cmd = makeMemCommand(1'b1, addr, nextRandom());
				end
			endcase
			issueCommand(cmd);
		end
		waitForDrain();
		reportTest("mixed");

		$display("summary: %0d tests run, %0d with errors, %0d errors in total", testsRun,
			testsFailed, reportedErrors);
		if (reportedErrors == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- execUnit.sv
/*
 * Scalar execution stage. Routes each accepted command to the ALU, the
 * move register or the load/store unit of the addressed bank, and holds
 * ready low while that unit is still busy.
 */

`timescale 1ns/1ps
`default_nettype none

`include "execUnit_defines.svh"

module execUnit
	import execUnitPkg::*;
(
	input	wire logic			clock,
	input	wire logic			reset,
	input	wire execCommand_t	command,
	output	logic				ready,

	// Write-back channels
	output	writeBack_t			aluResult,
	output	writeBack_t			moveResult,
	output	writeBack_t			evenLdStResult,
	output	writeBack_t			oddLdStResult,
	output	logic				evenStoreDone,
	output	logic				oddStoreDone,

	// Even bank Wishbone master
	output	logic				evenCyc,
	output	logic				evenStb,
	output	logic				evenWe,
	output	bankAddr_t			evenAdr,
	output	data_t				evenDatWrite,
	input	wire data_t			evenDatRead,
	input	wire logic			evenAck,

	// Odd bank Wishbone master
	output	logic				oddCyc,
	output	logic				oddStb,
	output	logic				oddWe,
	output	bankAddr_t			oddAdr,
	output	data_t				oddDatWrite,
	input	wire data_t			oddDatRead,
	input	wire logic			oddAck
);

	logic		isLdSt;
	logic		isStore;
	logic		accept;
	logic		evenBusy;
	logic		oddBusy;
	logic		evenStart;
	logic		oddStart;
	data_t		addrSum;
	wordAddr_t	effAddr;
	bankAddr_t	bankAddr;
	logic		moveValid;
	issueTag_t	moveTag;
	regIndex_t	moveDst;
	data_t		moveData;

	//////////////////////////////////////////////////
	// Decode and bank selection
	//////////////////////////////////////////////////
	assign isLdSt	= (command.opType == opLoad) || (command.opType == opStore);
	assign isStore	= (command.opType == opStore);
	assign addrSum	= command.src1 + command.src2;
	assign effAddr	= addrSum[`BANK_ADDR_WIDTH:0];		// Word address
	assign bankAddr	= effAddr[`BANK_ADDR_WIDTH:1];

	// Stall only loads and stores whose bank unit is occupied
	assign ready	= !(isLdSt && (effAddr[0] ? oddBusy : evenBusy));
	assign accept	= command.valid && ready;

	assign evenStart	= accept && isLdSt && !effAddr[0];
	assign oddStart		= accept && isLdSt && effAddr[0];

	//////////////////////////////////////////////////
	// Register-move path
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			moveValid <= 1'b0;
		end else begin
			moveValid <= accept && (command.opType == opMove);
		end
	end

	always_ff @(posedge clock) begin
		moveTag		<= command.tag;
		moveDst		<= command.dst;
		moveData	<= (command.aluOp == aluAdd) ? command.src1 : command.src3;	// Else immediate
	end

	assign moveResult = '{valid: moveValid, tag: moveTag, dst: moveDst, data: moveData};

	//////////////////////////////////////////////////
	// Execution paths
	//////////////////////////////////////////////////
	scalarAlu alu (
		.clock		(clock),
		.reset		(reset),
		.command	(command),
		.start		(accept && (command.opType == opArith)),
		.result		(aluResult)
	);

	loadStoreUnit evenLdSt (
		.clock		(clock),
		.reset		(reset),
		.start		(evenStart),
		.isStore	(isStore),
		.bankAddr	(bankAddr),
		.storeData	(command.src3),
		.tag		(command.tag),
		.dst		(command.dst),
		.busy		(evenBusy),
		.result		(evenLdStResult),
		.storeDone	(evenStoreDone),
		.cyc		(evenCyc),
		.stb		(evenStb),
		.we			(evenWe),
		.adr		(evenAdr),
		.datWrite	(evenDatWrite),
		.datRead	(evenDatRead),
		.ack		(evenAck)
	);

	loadStoreUnit oddLdSt (
		.clock		(clock),
		.reset		(reset),
		.start		(oddStart),
		.isStore	(isStore),
		.bankAddr	(bankAddr),
		.storeData	(command.src3),
		.tag		(command.tag),
		.dst		(command.dst),
		.busy		(oddBusy),
		.result		(oddLdStResult),
		.storeDone	(oddStoreDone),
		.cyc		(oddCyc),
		.stb		(oddStb),
		.we			(oddWe),
		.adr		(oddAdr),
		.datWrite	(oddDatWrite),
		.datRead	(oddDatRead),
		.ack		(oddAck)
	);

	// An accepted access finds its unit idle and occupies it next cycle
	evenAcceptIdle: assert property (@(posedge clock) disable iff (reset)
		evenStart |-> !evenBusy ##1 evenBusy);

	oddAcceptIdle: assert property (@(posedge clock) disable iff (reset)
		oddStart |-> !oddBusy ##1 oddBusy);

endmodule

`default_nettype wire

//--- execUnitPkg.sv
/*
 * Shared types of the execution lane: command, write-back and state
 * encodings. Imported by every RTL module and by the testbench.
 */

`default_nettype none

`include "execUnit_defines.svh"

package execUnitPkg;

	//////////////////////////////////////////////////
	// Plain vector types
	//////////////////////////////////////////////////
	typedef logic [`DATA_WIDTH-1:0]			data_t;			// Operand or result word
	typedef logic [`TAG_WIDTH-1:0]			issueTag_t;		// Issue number
	typedef logic [`REG_INDEX_WIDTH-1:0]	regIndex_t;		// Destination register
	typedef logic [`BANK_ADDR_WIDTH:0]		wordAddr_t;		// Bit 0 picks the bank
	typedef logic [`BANK_ADDR_WIDTH-1:0]	bankAddr_t;		// Index inside one bank

	//////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////
	typedef enum logic [1:0] {
		opArith,
		opMove,
		opLoad,
		opStore
	} opType_t;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluShiftLeft,
		aluShiftRight,		// Logical shift
		aluSetLessThan		// Signed compare
	} aluOp_t;

	typedef enum logic [1:0] {
		ldStIdle,
		ldStAccess,
		ldStFinish
	} ldStState_t;

	//////////////////////////////////////////////////
	// Command and result bundles
	//////////////////////////////////////////////////
	typedef struct packed {
		logic		valid;
		opType_t	opType;
		aluOp_t		aluOp;		// Also selects the move source
		regIndex_t	dst;
		issueTag_t	tag;
		data_t		src1;
		data_t		src2;
		data_t		src3;		// Store data or immediate
	} execCommand_t;

	typedef struct packed {
		logic		valid;
		issueTag_t	tag;
		regIndex_t	dst;
		data_t		data;
	} writeBack_t;

endpackage

`default_nettype wire

//--- execUnit_defines.svh
/*
 * Size macros for the scalar execution lane.
 * Include this header wherever a width or depth is needed; the package
 * builds its types on top of these values.
 */

`ifndef EXEC_UNIT_DEFINES_SVH
`define EXEC_UNIT_DEFINES_SVH

// Operand and result word
`define DATA_WIDTH		32

// Issue number carried with every command
`define TAG_WIDTH		4

// Destination register index
`define REG_INDEX_WIDTH	5

// Word address bits inside one bank
`define BANK_ADDR_WIDTH	8

`endif

//--- loadStoreUnit.sv
/*
 * Load/store sequencer for one memory bank. A request is latched on start
 * and carried out as one Wishbone classic cycle; loads return a write-back
 * result, stores give a one-cycle storeDone pulse.
 */

`timescale 1ns/1ps
`default_nettype none

module loadStoreUnit
	import execUnitPkg::*;
(
	input	wire logic		clock,
	input	wire logic		reset,

	// Request side
	input	wire logic		start,
	input	wire logic		isStore,
	input	wire bankAddr_t	bankAddr,
	input	wire data_t		storeData,
	input	wire issueTag_t	tag,
	input	wire regIndex_t	dst,
	output	logic			busy,
	output	writeBack_t		result,
	output	logic			storeDone,

	// Wishbone master
	output	logic			cyc,
	output	logic			stb,
	output	logic			we,
	output	bankAddr_t		adr,
	output	data_t			datWrite,
	input	wire data_t		datRead,
	input	wire logic		ack
);

	ldStState_t	state;
	logic		isStoreQ;
	logic		loadValid;
	bankAddr_t	addrQ;
	data_t		dataQ;
	data_t		loadData;
	issueTag_t	tagQ;
	regIndex_t	dstQ;

	logic		takeRequest;
	logic		busDone;

	assign takeRequest	= (state == ldStIdle) && start;
	assign busDone		= (state == ldStAccess) && ack;

	//////////////////////////////////////////////////
	// Sequencer
	//////////////////////////////////////////////////
	always_ff @(posedge clock) begin
		if (reset) begin
			state		<= ldStIdle;
			isStoreQ	<= 1'b0;
			cyc			<= 1'b0;
			stb			<= 1'b0;
			loadValid	<= 1'b0;
			storeDone	<= 1'b0;
		end else begin
			loadValid	<= 1'b0;	// Both are single-cycle pulses
			storeDone	<= 1'b0;
			case (state)
				ldStIdle: begin
					if (start) begin
						state		<= ldStAccess;
						isStoreQ	<= isStore;
						cyc			<= 1'b1;
						stb			<= 1'b1;
					end
				end
				ldStAccess: begin
					if (ack) begin
						state		<= ldStFinish;
						cyc			<= 1'b0;	// Released right after the acknowledge
						stb			<= 1'b0;
						loadValid	<= ~isStoreQ;
						storeDone	<= isStoreQ;
					end
				end
				ldStFinish: state <= ldStIdle;
				default:	state <= ldStIdle;
			endcase
		end
	end

	// Request payload and loaded word
	always_ff @(posedge clock) begin
		if (takeRequest) begin
			addrQ	<= bankAddr;
			dataQ	<= storeData;
			tagQ	<= tag;
			dstQ	<= dst;
		end
		if (busDone) begin
			loadData <= datRead;
		end
	end

	assign busy		= (state != ldStIdle);
	assign we		= cyc & isStoreQ;
	assign adr		= addrQ;
	assign datWrite	= dataQ;

	assign result	= '{valid: loadValid, tag: tagQ, dst: dstQ, data: loadData};

	// The issuing side must hold requests while this unit works
	noStartWhenBusy: assert property (@(posedge clock) disable iff (reset)
		start |-> !busy);

	// Strobe only inside a bus cycle
	stbInsideCyc: assert property (@(posedge clock) disable iff (reset)
		stb |-> cyc);

endmodule

`default_nettype wire

//--- scalarAlu.sv
/*
 * Two-stage integer pipeline. Operands are captured on start, the result
 * comes out two cycles later with its tag and destination register.
 */

`timescale 1ns/1ps
`default_nettype none

module scalarAlu
	import execUnitPkg::*;
(
	input	wire logic			clock,
	input	wire logic			reset,
	input	wire execCommand_t	command,
	input	wire logic			start,
	output	writeBack_t			result
);

	// Stage one
	logic		s1Valid;
	aluOp_t		s1Op;
	issueTag_t	s1Tag;
	regIndex_t	s1Dst;
	data_t		s1A;
	data_t		s1B;

	// Stage two
	logic		s2Valid;
	issueTag_t	s2Tag;
	regIndex_t	s2Dst;
	data_t		s2Data;

	data_t		aluOut;

	always_ff @(posedge clock) begin
		if (reset) begin
			s1Valid <= 1'b0;
			s2Valid <= 1'b0;
		end else begin
			s1Valid <= start;
			s2Valid <= s1Valid;
		end
	end

	always_ff @(posedge clock) begin
		s1Op	<= command.aluOp;
		s1Tag	<= command.tag;
		s1Dst	<= command.dst;
		s1A		<= command.src1;
		s1B		<= command.src2;
		s2Tag	<= s1Tag;
		s2Dst	<= s1Dst;
		s2Data	<= aluOut;
	end

	always_comb begin
		case (s1Op)
			aluAdd:			aluOut = s1A + s1B;
			aluSub:			aluOut = s1A - s1B;
			aluAnd:			aluOut = s1A & s1B;
			aluOr:			aluOut = s1A | s1B;
			aluXor:			aluOut = s1A ^ s1B;
			aluShiftLeft:	aluOut = s1A << s1B[4:0];		// Low five bits only
			aluShiftRight:	aluOut = s1A >> s1B[4:0];
			aluSetLessThan:	aluOut = data_t'($signed(s1A) < $signed(s1B));
			default:		aluOut = '0;
		endcase
	end

	assign result = '{valid: s2Valid, tag: s2Tag, dst: s2Dst, data: s2Data};

	// Every accepted operation leaves the pipe exactly two cycles on
	validLatency: assert property (@(posedge clock) disable iff (reset)
		result.valid == $past(start, 2));

endmodule

`default_nettype wire
